// File: design/rx_align_pkg.sv
/*
 * Frame aligner shared definitions: link word type, alignment word pattern
 * and the lock state encoding
 */
package rx_align_pkg;

   // One link word as carried on the receive path
   typedef logic [63:0] word_t;

   // Frame alignment word
   // Chosen with balanced ones and zeros and few long runs, so random
   // scrambled data is unlikely to mimic it
   localparam word_t FAW_PATTERN = 64'hf628_c3a5_5a3c_27d9;

   // Lock search states
   // HUNT     waiting for any alignment word
   // VERIFY   counting alignment words at the expected spacing
   // LOCKED   frame position fixed until the aligner is disabled
   typedef enum logic [1:0] {
      ST_HUNT   = 2'd0,
      ST_VERIFY = 2'd1,
      ST_LOCKED = 2'd2
   } lock_state_t;

endpackage

// File: design/rx_faw_matcher.sv
`timescale 1ns/1ps
/*
 * FAW matcher: registers each link word, compares it with the alignment
 * pattern and times the gap from one pattern hit to the next
 */
module rx_faw_matcher
   import rx_align_pkg::*;
#(
   parameter int FAW_DISTANCE = 64
) (
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  enable_i,
   input  word_t tdata_i,
   output logic  faw_hit_o,
   output logic  faw_spaced_o,
   output logic  faw_missing_o
);

   // Gap counter must reach FAW_DISTANCE so it can saturate there
   localparam int GAP_W = $clog2(FAW_DISTANCE + 1);

   typedef logic [GAP_W-1:0] gap_cnt_t;

   // Non-FAW words expected between two correctly spaced hits
   localparam gap_cnt_t GAP_LAST = gap_cnt_t'(FAW_DISTANCE - 1);
   localparam gap_cnt_t GAP_MAX  = gap_cnt_t'(FAW_DISTANCE);

   word_t    word_q;
   logic     word_vld_q;
   logic     is_faw;
   logic     seen_q;
   gap_cnt_t gap_q;

   // Input stage, payload only
   always_ff @(posedge clk_i) begin
      word_q <= tdata_i;
   end

   // Marks a word that was captured while the aligner was enabled
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_i) begin
         word_vld_q <= 1'b0;
      end else begin
         word_vld_q <= 1'b1;
      end
   end

   assign is_faw = word_vld_q && (word_q == FAW_PATTERN);

   // Flag stage
   // seen_q holds off the spaced and missing strobes until a first hit
   // has given the gap counter a reference point
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_i) begin
         faw_hit_o     <= 1'b0;
         faw_spaced_o  <= 1'b0;
         faw_missing_o <= 1'b0;
         seen_q        <= 1'b0;
         gap_q         <= '0;
      end else begin
         faw_hit_o     <= is_faw;
         faw_spaced_o  <= is_faw && seen_q && (gap_q == GAP_LAST);
         faw_missing_o <= !is_faw && seen_q && (gap_q == GAP_LAST);

         if (is_faw) begin
            seen_q <= 1'b1;
            gap_q  <= '0;
         end else if (seen_q && (gap_q != GAP_MAX)) begin
            // Saturate so a long silence cannot wrap into a false spacing
            gap_q <= gap_q + 1'b1;
         end
      end
   end

endmodule

// File: design/rx_lock_fsm.sv
`timescale 1ns/1ps
/*
 * Lock FSM: hunts for an alignment word, verifies a run of correctly
 * spaced ones and pulses lock_start_o once when the run is complete
 */
module rx_lock_fsm
   import rx_align_pkg::*;
#(
   parameter int LOCK_COUNT = 8
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic enable_i,
   input  logic faw_hit_i,
   input  logic faw_spaced_i,
   input  logic faw_missing_i,
   output logic lock_start_o
);

   localparam int VCNT_W = $clog2(LOCK_COUNT + 1);

   typedef logic [VCNT_W-1:0] vcnt_t;

   localparam vcnt_t VCNT_ONE  = vcnt_t'(1);
   localparam vcnt_t VCNT_FULL = vcnt_t'(LOCK_COUNT);

   lock_state_t state_q;
   lock_state_t state_d;
   vcnt_t       cnt_q;
   vcnt_t       cnt_d;
   logic        lock_start_d;

   // Next state
   always_comb begin
      state_d      = state_q;
      cnt_d        = cnt_q;
      lock_start_d = 1'b0;

      unique case (state_q)
         ST_HUNT: begin
            // Any alignment word is taken as a candidate frame start
            if (faw_hit_i) begin
               state_d = ST_VERIFY;
               cnt_d   = VCNT_ONE;
            end
         end

         ST_VERIFY: begin
            if (faw_spaced_i) begin
               cnt_d = cnt_q + 1'b1;
               if (cnt_d == VCNT_FULL) begin
                  state_d      = ST_LOCKED;
                  lock_start_d = 1'b1;
               end
            end else if (faw_hit_i) begin
               // Hit at the wrong distance, treat it as a new candidate
               cnt_d = VCNT_ONE;
            end else if (faw_missing_i) begin
               state_d = ST_HUNT;
               cnt_d   = '0;
            end
         end

         ST_LOCKED: begin
            // Data is ignored here, only disable leaves this state
            state_d = ST_LOCKED;
         end

         default: begin
            state_d = ST_HUNT;
            cnt_d   = '0;
         end
      endcase
   end

   // State registers
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_i) begin
         state_q      <= ST_HUNT;
         cnt_q        <= '0;
         lock_start_o <= 1'b0;
      end else begin
         state_q      <= state_d;
         cnt_q        <= cnt_d;
         lock_start_o <= lock_start_d;
      end
   end

endmodule

// File: design/rx_boundary_counter.sv
`timescale 1ns/1ps
/*
 * Boundary counter: free-running slot counter started at lock, marks
 * frame boundaries at slot 0 and CRC boundaries every CRC_INTERVAL slots
 */
module rx_boundary_counter #(
   parameter int FAW_DISTANCE = 64,
   parameter int CRC_INTERVAL = 7
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic enable_i,
   input  logic lock_start_i,
   output logic locked_o,
   output logic faw_boundary_o,
   output logic crc_boundary_o
);

   localparam int SLOT_W = (FAW_DISTANCE > 1) ? $clog2(FAW_DISTANCE) : 1;
   localparam int SUB_W  = (CRC_INTERVAL > 1) ? $clog2(CRC_INTERVAL) : 1;

   typedef logic [SLOT_W-1:0] slot_t;
   typedef logic [SUB_W-1:0]  sub_t;

   localparam slot_t SLOT_LAST = slot_t'(FAW_DISTANCE - 1);
   localparam sub_t  SUB_LAST  = sub_t'(CRC_INTERVAL - 1);

   slot_t slot_q;
   slot_t slot_d;
   sub_t  sub_q;
   sub_t  sub_d;

   // Slot and sub-counter advance
   // Sub-counter realigns at slot 0 since the frame is one word longer
   // than a whole number of CRC intervals
   always_comb begin
      if (slot_q == SLOT_LAST) begin
         slot_d = '0;
         sub_d  = '0;
      end else begin
         slot_d = slot_q + 1'b1;
         sub_d  = (sub_q == SUB_LAST) ? '0 : sub_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_i) begin
         locked_o       <= 1'b0;
         faw_boundary_o <= 1'b0;
         crc_boundary_o <= 1'b0;
         slot_q         <= '0;
         sub_q          <= '0;
      end else if (lock_start_i) begin
         // First locked cycle is also the first frame boundary
         locked_o       <= 1'b1;
         faw_boundary_o <= 1'b1;
         crc_boundary_o <= 1'b0;
         slot_q         <= '0;
         sub_q          <= '0;
      end else if (locked_o) begin
         slot_q         <= slot_d;
         sub_q          <= sub_d;
         faw_boundary_o <= (slot_d == '0);
         crc_boundary_o <= (sub_d == '0) && (slot_d != '0);
      end
   end

endmodule

// File: design/rx_frame_align.sv
`timescale 1ns/1ps
/*
 * Receive frame aligner top: FAW matcher, lock FSM and boundary counter
 * in a chain, with the link data passed straight through
 */
module rx_frame_align
   import rx_align_pkg::*;
#(
   parameter int FAW_DISTANCE = 64,
   parameter int LOCK_COUNT   = 8,
   parameter int CRC_INTERVAL = 7
) (
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  enable_i,
   input  word_t tdata_i,
   output word_t tdata_o,
   output logic  locked_o,
   output logic  faw_boundary_o,
   output logic  crc_boundary_o
);

   logic faw_hit;
   logic faw_spaced;
   logic faw_missing;
   logic lock_start;

   // Zero latency data path
   assign tdata_o = tdata_i;

   rx_faw_matcher #(
      .FAW_DISTANCE (FAW_DISTANCE)
   ) u_faw_matcher (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .enable_i      (enable_i),
      .tdata_i       (tdata_i),
      .faw_hit_o     (faw_hit),
      .faw_spaced_o  (faw_spaced),
      .faw_missing_o (faw_missing)
   );

   rx_lock_fsm #(
      .LOCK_COUNT (LOCK_COUNT)
   ) u_lock_fsm (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .enable_i      (enable_i),
      .faw_hit_i     (faw_hit),
      .faw_spaced_i  (faw_spaced),
      .faw_missing_i (faw_missing),
      .lock_start_o  (lock_start)
   );

   rx_boundary_counter #(
      .FAW_DISTANCE (FAW_DISTANCE),
      .CRC_INTERVAL (CRC_INTERVAL)
   ) u_boundary_counter (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .enable_i       (enable_i),
      .lock_start_i   (lock_start),
      .locked_o       (locked_o),
      .faw_boundary_o (faw_boundary_o),
      .crc_boundary_o (crc_boundary_o)
   );

endmodule

// File: verification/tb_rx_frame_align.sv
`timescale 1ns/1ps
/*
 * Testbench for the receive frame aligner: LFSR word stream with FAWs,
 * word level reference model and per-cycle output checks
 */
module tb_rx_frame_align
   import rx_align_pkg::*;
();

   localparam int FAW_DISTANCE          = 64;
   localparam int LOCK_COUNT            = 8;
   localparam int CRC_INTERVAL          = 7;
   localparam int FAW_TO_LOCKED_LATENCY = 4;
   localparam int CLK_HALF              = 20;
   localparam int LOCK_TIMEOUT          = (LOCK_COUNT + 4) * FAW_DISTANCE;
   // Word index in a clean run at which locked_o is first seen high
   localparam int WORDS_TO_LOCK = (LOCK_COUNT - 1) * FAW_DISTANCE + FAW_TO_LOCKED_LATENCY;

   logic  clk_i = 1'b0;
   logic  rst_n_i;
   logic  enable_i;
   word_t tdata_i;
   word_t tdata_o;
   logic  locked_o;
   logic  faw_boundary_o;
   logic  crc_boundary_o;

   logic [31:0] lfsr_q    = 32'h9a6e2911;
   string       test_name = "reset";

   // Reference model state, updated at each rising edge
   lock_state_t m_state    = ST_HUNT;
   logic        m_seen     = 1'b0;
   int          m_gap      = 0;
   int          m_cnt      = 0;
   logic [3:0]  lock_hist  = '0;
   int          exp_slot   = 0;
   logic        exp_locked = 1'b0;
   logic        exp_faw    = 1'b0;
   logic        exp_crc    = 1'b0;

   // Observed strobe counts
   int          faw_cnt = 0;
   int          crc_cnt = 0;

   always #CLK_HALF clk_i = ~clk_i;

   rx_frame_align #(
      .FAW_DISTANCE (FAW_DISTANCE),
      .LOCK_COUNT   (LOCK_COUNT),
      .CRC_INTERVAL (CRC_INTERVAL)
   ) u_rx_frame_align (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .enable_i       (enable_i),
      .tdata_i        (tdata_i),
      .tdata_o        (tdata_o),
      .locked_o       (locked_o),
      .faw_boundary_o (faw_boundary_o),
      .crc_boundary_o (crc_boundary_o)
   );

   // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
   function automatic logic lfsr_step();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         r = {r[62:0], lfsr_step()};
      end
      return r;
   endfunction

   // Payload word that can never be taken for an alignment word
   function automatic word_t random_word();
      word_t w;
      w = rand_bits(64);
      if (w == FAW_PATTERN) begin
         w[0] = ~w[0];
      end
      return w;
   endfunction

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what,
                  expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic drive_word(input word_t w, input logic en);
      @(posedge clk_i);
      tdata_i  <= w;
      enable_i <= en;
   endtask

   // One frame of len words, FAW in the first slot unless dropped
   task automatic send_frame(input logic drop, input int len);
      word_t w;
      int    i;
      for (i = 0; i < len; i++) begin
         w = random_word();
         if (!drop && i == 0) begin
            w = FAW_PATTERN;
         end
         drive_word(w, 1'b1);
      end
   endtask

   task automatic start_test(input string name);
      @(posedge clk_i);
      test_name = name;
   endtask

   // Holds enable low, then confirms all outputs are cleared
   task automatic disable_for(input int cycles);
      repeat (cycles) drive_word(random_word(), 1'b0);
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("locked_o while disabled", 64'd0, 64'(locked_o));
      check_value("faw_boundary_o while disabled", 64'd0, 64'(faw_boundary_o));
      check_value("crc_boundary_o while disabled", 64'd0, 64'(crc_boundary_o));
   endtask

   // Clean FAW stream from a frame start until locked_o is seen
   task automatic wait_lock(input string what);
      int    n;
      logic  got;
      word_t w;
      n   = 0;
      got = 1'b0;
      while (!got && n < LOCK_TIMEOUT) begin
         w = (n % FAW_DISTANCE == 0) ? FAW_PATTERN : random_word();
         drive_word(w, 1'b1);
         @(negedge clk_i);
         if (locked_o) begin
            got = 1'b1;
         end else begin
            n++;
         end
      end
      if (!got) begin
         $display("Timeout: locked_o never rose during %s within %0d words", what,
                  LOCK_TIMEOUT);
         $display("TESTS FAILED");
         $fatal(1, "lock wait timed out");
      end else begin
         check_value("words until lock", 64'(WORDS_TO_LOCK), 64'(n));
      end
   endtask

   // Word level model of the lock rules and the boundary schedule
   always @(posedge clk_i) begin : model_step
      logic hit;
      logic spaced;
      logic missing;
      logic lock_evt;
      if (!rst_n_i || !enable_i) begin
         m_state    = ST_HUNT;
         m_seen     = 1'b0;
         m_gap      = 0;
         m_cnt      = 0;
         lock_hist  = '0;
         exp_slot   = 0;
         exp_locked = 1'b0;
         exp_faw    = 1'b0;
         exp_crc    = 1'b0;
      end else begin
         hit      = (tdata_i == FAW_PATTERN);
         spaced   = hit && m_seen && (m_gap == FAW_DISTANCE - 1);
         missing  = !hit && m_seen && (m_gap == FAW_DISTANCE - 1);
         lock_evt = 1'b0;
         if (hit) begin
            m_seen = 1'b1;
            m_gap  = 0;
         end else if (m_seen) begin
            m_gap++;
         end

         case (m_state)
            ST_HUNT: begin
               if (hit) begin
                  m_state = ST_VERIFY;
                  m_cnt   = 1;
               end
            end
            ST_VERIFY: begin
               if (spaced) begin
                  m_cnt++;
                  if (m_cnt == LOCK_COUNT) begin
                     m_state  = ST_LOCKED;
                     lock_evt = 1'b1;
                  end
               end else if (hit) begin
                  m_cnt = 1;
               end else if (missing) begin
                  m_state = ST_HUNT;
                  m_cnt   = 0;
               end
            end
            default: begin
            end
         endcase

         // Lock decision reaches the outputs three edges later
         lock_hist = {lock_hist[2:0], lock_evt};
         if (lock_hist[3]) begin
            exp_locked = 1'b1;
            exp_slot   = 0;
            exp_faw    = 1'b1;
            exp_crc    = 1'b0;
         end else if (exp_locked) begin
            exp_slot = (exp_slot + 1) % FAW_DISTANCE;
            exp_faw  = (exp_slot == 0);
            exp_crc  = (exp_slot != 0) && (exp_slot % CRC_INTERVAL == 0);
         end
      end
   end

   // Outputs are compared mid-cycle, away from the driving edge
   always @(negedge clk_i) begin
      check_value("tdata_o", tdata_i, tdata_o);
      check_value("locked_o", 64'(exp_locked), 64'(locked_o));
      check_value("faw_boundary_o", 64'(exp_faw), 64'(faw_boundary_o));
      check_value("crc_boundary_o", 64'(exp_crc), 64'(crc_boundary_o));
      if (faw_boundary_o) begin
         faw_cnt++;
      end
      if (crc_boundary_o) begin
         crc_cnt++;
      end
   end

   initial begin
      int faw_start;
      int crc_start;
      int i;
      rst_n_i  <= 1'b0;
      enable_i <= 1'b0;
      tdata_i  <= '0;
      repeat (3) @(posedge clk_i);
      rst_n_i  <= 1'b1;
      enable_i <= 1'b1;

      start_test("lock_latency");
      wait_lock("first lock after reset");

      // Three whole frames hold 3 frame and 27 CRC boundaries
      start_test("boundary_pattern");
      faw_start = faw_cnt;
      crc_start = crc_cnt;
      repeat (3 * FAW_DISTANCE) drive_word(random_word(), 1'b1);
      check_value("frame boundaries", 64'd3, 64'(faw_cnt - faw_start));
      check_value("crc boundaries", 64'(3 * ((FAW_DISTANCE - 1) / CRC_INTERVAL)),
                  64'(crc_cnt - crc_start));

      start_test("broken_verify");
      disable_for(2);
      repeat (4) send_frame(1'b0, FAW_DISTANCE);
      send_frame(1'b1, FAW_DISTANCE);
      wait_lock("lock after a dropped FAW");
      disable_for(2);
      repeat (3) send_frame(1'b0, FAW_DISTANCE);
      // Short frame makes the next FAW arrive early
      send_frame(1'b0, FAW_DISTANCE - 1 - int'(rand_bits(5)));
      wait_lock("lock after a displaced FAW");

      start_test("lock_holds");
      for (i = 0; i < 6; i++) begin
         case (int'(rand_bits(2)))
            0: send_frame(1'b1, FAW_DISTANCE);
            1: send_frame(1'b0, FAW_DISTANCE);
            default: send_frame(1'b0, 16 + int'(rand_bits(7)));
         endcase
      end

      start_test("enable_clears");
      disable_for(1 + int'(rand_bits(2)));
      wait_lock("lock after enable was dropped");
      repeat (FAW_DISTANCE) drive_word(random_word(), 1'b1);

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: verilog.f
design/rx_align_pkg.sv
design/rx_faw_matcher.sv
design/rx_lock_fsm.sv
design/rx_boundary_counter.sv
design/rx_frame_align.sv
verification/tb_rx_frame_align.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the frame aligner testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
   --top-module tb_rx_frame_align \
   -f verilog.f \
   -o tb_sim

./obj_dir/tb_sim 2>&1 | tee "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
   echo "Simulation ended without a pass report, see $LOG"
   exit 1
fi
